//--- design/rf_pkg.sv
`default_nettype none

package rf_pkg;

  //////////////////////////////////////////////////////////////////////
  // widths
  //////////////////////////////////////////////////////////////////////
  localparam int xlen       = 32;  // one machine word
  localparam int reg_addr_w = 5;   // 32 architectural registers
  localparam int nregs      = 2 ** reg_addr_w;
  localparam int imm_w      = 17;  // immediate field in the i layout

  // opcode map, gaps are illegal codes
  typedef enum logic [4:0] {
    op_add  = 5'd0,
    op_sub  = 5'd1,
    op_and  = 5'd2,
    op_or   = 5'd3,
    op_xor  = 5'd4,
    op_sll  = 5'd5,
    op_srl  = 5'd6,
    op_eq   = 5'd8,   // compare group
    op_slt  = 5'd9,
    op_sltu = 5'd10,
    op_addi = 5'd16,  // immediate group
    op_andi = 5'd18,
    op_ori  = 5'd19,
    op_xori = 5'd20
  } op_e;

  //////////////////////////////////////////////////////////////////////
  // instruction layouts, opcode always in [31:27]
  //////////////////////////////////////////////////////////////////////
  typedef struct packed {
    op_e                   opcode;
    logic [reg_addr_w-1:0] rd;
    logic [reg_addr_w-1:0] rs1;
    logic [reg_addr_w-1:0] rs2;
    logic [11:0]           unused;  // don't care in r form
  } instr_r_t;

  typedef struct packed {
    op_e                   opcode;
    logic [reg_addr_w-1:0] rd;
    logic [reg_addr_w-1:0] rs1;
    logic [imm_w-1:0]      imm;     // two's complement
  } instr_i_t;

  typedef union packed {
    instr_r_t r;
    instr_i_t i;
  } instr_u;

  typedef enum logic [1:0] {
    unit_none = 2'd0,
    unit_alu  = 2'd1,
    unit_cmp  = 2'd2
  } unit_sel_e;

  // decoded instruction, also the execute stage register
  typedef struct packed {
    logic [reg_addr_w-1:0] rd;
    logic [reg_addr_w-1:0] rs1;
    logic [reg_addr_w-1:0] rs2;
    op_e                   op;
    logic                  use_imm;
    logic [xlen-1:0]       imm;
    unit_sel_e             unit;
    logic                  valid;
  } dec_t;

  // write request into the rf, same thing goes out as the result
  typedef struct packed {
    logic                  valid;
    logic [reg_addr_w-1:0] rd;
    logic [xlen-1:0]       data;
  } wb_t;

endpackage

`default_nettype wire

//--- design/instr_decode.sv
`timescale 1ns/1ps
`default_nettype none

module instr_decode (
  input  rf_pkg::instr_u instr,
  input  logic           instr_valid,
  output rf_pkg::dec_t   dec
);
  import rf_pkg::*;

  logic [xlen-1:0] imm_sx;  // immediate sign extended to a word

  // replicate bit 16 into the upper bits
  assign imm_sx = {{(xlen-imm_w){instr.i.imm[imm_w-1]}}, instr.i.imm};

  //////////////////////////////////////////////////////////////////////
  // opcode classification
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    dec         = '0;            // rs2 / imm zero unless used
    dec.valid   = instr_valid;   // carried for illegal codes too
    dec.rd      = instr.r.rd;
    dec.rs1     = instr.r.rs1;   // same bits in both layouts
    dec.op      = instr.r.opcode;
    dec.unit    = unit_none;     // anything unmatched is illegal

    case (instr.r.opcode)
      // register-register alu forms
      op_add, op_sub, op_and, op_or, op_xor, op_sll, op_srl: begin
        dec.rs2  = instr.r.rs2;
        dec.unit = unit_alu;
      end
      // compares always read two registers
      op_eq, op_slt, op_sltu: begin
        dec.rs2  = instr.r.rs2;
        dec.unit = unit_cmp;
      end
      // immediate forms fold onto the base alu op
      op_addi: begin
        dec.op = op_add;
        dec.use_imm = 1'b1;
        dec.imm     = imm_sx;
        dec.unit    = unit_alu;
      end
      op_andi: begin
        dec.op = op_and;
        dec.use_imm = 1'b1;
        dec.imm     = imm_sx;
        dec.unit    = unit_alu;
      end
      op_ori: begin
        dec.op = op_or;
        dec.use_imm = 1'b1;
        dec.imm     = imm_sx;
        dec.unit    = unit_alu;
      end
      op_xori: begin
        dec.op = op_xor;
        dec.use_imm = 1'b1;
        dec.imm     = imm_sx;
        dec.unit    = unit_alu;
      end
      default: begin
        dec.unit = unit_none;    // writeback turns this into illegal
      end
    endcase
  end

endmodule

`default_nettype wire

//--- design/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file #(
  parameter int data_width = rf_pkg::xlen
) (
  input  logic                          clk,
  input  logic                          arst_n,
  input  logic [rf_pkg::reg_addr_w-1:0] raddr0,
  input  logic [rf_pkg::reg_addr_w-1:0] raddr1,
  input  rf_pkg::wb_t                   wr,
  output logic [data_width-1:0]         rdata0,
  output logic [data_width-1:0]         rdata1
);
  import rf_pkg::*;

  // r0 has no storage, it is hardwired to zero
  logic [data_width-1:0] mem [1:nregs-1];

  logic wr_en;  // qualified write, r0 writes dropped

  assign wr_en = wr.valid && (wr.rd != '0);

  //////////////////////////////////////////////////////////////////////
  // write port
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 1; i < nregs; i++) begin
        mem[i] <= '0;
      end
    end else if (wr_en) begin
      mem[wr.rd] <= wr.data;
    end
  end

  // one read port, with bypass of the write committing this edge
  function automatic logic [data_width-1:0] read_port(
    input logic [reg_addr_w-1:0] addr
  );
    if (addr == '0)
      return '0;                 // r0 reads zero
    else if (wr_en && (wr.rd == addr))
      return wr.data;            // write data wins over stale entry
    else
      return mem[addr];
  endfunction

  //////////////////////////////////////////////////////////////////////
  // synchronous read ports
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    rdata0 <= read_port(raddr0);
    rdata1 <= read_port(raddr1);
  end

endmodule

`default_nettype wire

//--- design/alu_unit.sv
`timescale 1ns/1ps
`default_nettype none

module alu_unit #(
  parameter int data_width = rf_pkg::xlen
) (
  input  rf_pkg::op_e           op,
  input  logic                  use_imm,
  input  logic [data_width-1:0] a,
  input  logic [data_width-1:0] b,
  input  logic [data_width-1:0] imm,
  output logic [data_width-1:0] y
);
  import rf_pkg::*;

  localparam int sh_w = $clog2(data_width);  // 5 for a 32 bit word

  logic [data_width-1:0] b_op;   // second operand after imm select
  logic [sh_w-1:0]       shamt;  // shift distance

  //////////////////////////////////////////////////////////////////////
  // operand select
  //////////////////////////////////////////////////////////////////////
  assign b_op  = use_imm ? imm : b;
  assign shamt = b_op[sh_w-1:0];   // upper bits ignored

  //////////////////////////////////////////////////////////////////////
  // operations
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    case (op)
      op_add: begin
        y = a + b_op;             // wraps, carry dropped
      end
      op_sub: begin
        y = a - b_op;             // wraps as well
      end
      op_and: begin
        y = a & b_op;
      end
      op_or: begin
        y = a | b_op;
      end
      op_xor: begin
        y = a ^ b_op;
      end
      op_sll: begin
        y = a << shamt;           // zero fill from the right
      end
      op_srl: begin
        y = a >> shamt;           // logical, zero fill from the left
      end
      default: begin
        y = '0;                   // compare ops and illegal codes
      end
    endcase
  end

endmodule

`default_nettype wire

//--- design/compare_unit.sv
`timescale 1ns/1ps
`default_nettype none

module compare_unit #(
  parameter int data_width = rf_pkg::xlen
) (
  input  rf_pkg::op_e           op,
  input  logic [data_width-1:0] a,
  input  logic [data_width-1:0] b,
  output logic [data_width-1:0] y
);
  import rf_pkg::*;

  logic eq;    // a == b
  logic lt_s;  // a < b two's complement
  logic lt_u;  // a < b magnitude

  //////////////////////////////////////////////////////////////////////
  // all three comparisons in parallel
  //////////////////////////////////////////////////////////////////////
  assign eq   = (a == b);
  assign lt_s = ($signed(a) < $signed(b));
  assign lt_u = (a < b);

  // pick one, result lands in bit 0
  always_comb begin
    y = '0;                       // upper bits always zero
    case (op)
      op_eq: begin
        y[0] = eq;
      end
      op_slt: begin
        y[0] = lt_s;              // differs from sltu when signs differ
      end
      op_sltu: begin
        y[0] = lt_u;
      end
      default: begin
        y[0] = 1'b0;              // alu ops and illegal codes
      end
    endcase
  end

endmodule

`default_nettype wire

//--- design/writeback_sel.sv
`timescale 1ns/1ps
`default_nettype none

module writeback_sel #(
  parameter int data_width = rf_pkg::xlen
) (
  input  logic                  clk,
  input  logic                  arst_n,
  input  rf_pkg::dec_t          dec,
  input  logic [data_width-1:0] alu_y,
  input  logic [data_width-1:0] cmp_y,
  output rf_pkg::wb_t           wb,
  output logic                  illegal
);
  import rf_pkg::*;

  logic [data_width-1:0] sel_y;   // result chosen by unit
  logic                  legal;   // decoded into a real unit

  logic                  valid_q;
  logic                  illegal_q;
  logic [reg_addr_w-1:0] rd_q;
  logic [data_width-1:0] data_q;

  assign legal = (dec.unit != unit_none);

  always_comb begin
    case (dec.unit)
      unit_alu: sel_y = alu_y;
      unit_cmp: sel_y = cmp_y;
      default:  sel_y = '0;       // nothing to write
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // result register
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      valid_q   <= 1'b0;
      illegal_q <= 1'b0;
    end else begin
      valid_q   <= dec.valid && legal;    // one pulse per legal op
      illegal_q <= dec.valid && !legal;
    end
  end

  always_ff @(posedge clk) begin
    rd_q   <= dec.rd;
    data_q <= sel_y;
  end

  assign wb      = '{valid: valid_q, rd: rd_q, data: data_q};
  assign illegal = illegal_q;

endmodule

`default_nettype wire

//--- design/exec_core.sv
`timescale 1ns/1ps
`default_nettype none

module exec_core #(
  parameter int data_width = rf_pkg::xlen
) (
  input  logic           clk,
  input  logic           arst_n,
  input  logic           instr_valid,
  input  rf_pkg::instr_u instr,
  output rf_pkg::wb_t    result,
  output logic           illegal
);
  import rf_pkg::*;

  dec_t                  dec_d;    // decode output, same cycle as strobe
  dec_t                  ex_q;     // execute stage
  wb_t                   wb;       // registered result, also the rf write
  logic [data_width-1:0] rdata0;
  logic [data_width-1:0] rdata1;
  logic [data_width-1:0] op_a;     // operands after forwarding
  logic [data_width-1:0] op_b;
  logic [data_width-1:0] alu_y;
  logic [data_width-1:0] cmp_y;
  logic                  fwd_a;
  logic                  fwd_b;

  //////////////////////////////////////////////////////////////////////
  // decode and operand read
  //////////////////////////////////////////////////////////////////////
  instr_decode u_decode (
    .instr       (instr),
    .instr_valid (instr_valid),
    .dec         (dec_d)
  );

  reg_file #(
    .data_width (data_width)
  ) u_reg_file (
    .clk    (clk),
    .arst_n (arst_n),
    .raddr0 (dec_d.rs1),
    .raddr1 (dec_d.rs2),
    .wr     (wb),        // commits one edge after result registers
    .rdata0 (rdata0),
    .rdata1 (rdata1)
  );

  // execute stage register, lines up with the rf read data
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ex_q <= '0;        // valid low
    end else begin
      ex_q <= dec_d;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // forwarding from the result register
  //////////////////////////////////////////////////////////////////////
  // producer sits in wb while a back to back consumer executes
  // and its write has not reached the rf yet
  // a gap of one cycle is covered by the rf bypass instead
  assign fwd_a = wb.valid && (wb.rd == ex_q.rs1) && (ex_q.rs1 != '0);
  assign fwd_b = wb.valid && (wb.rd == ex_q.rs2) && (ex_q.rs2 != '0);

  assign op_a = fwd_a ? wb.data : rdata0;
  assign op_b = fwd_b ? wb.data : rdata1;   // rs2 is 0 for imm forms

  //////////////////////////////////////////////////////////////////////
  // the two units side by side
  //////////////////////////////////////////////////////////////////////
  alu_unit #(
    .data_width (data_width)
  ) u_alu (
    .op      (ex_q.op),
    .use_imm (ex_q.use_imm),
    .a       (op_a),
    .b       (op_b),
    .imm     (ex_q.imm),
    .y       (alu_y)
  );

  compare_unit #(
    .data_width (data_width)
  ) u_cmp (
    .op (ex_q.op),
    .a  (op_a),
    .b  (op_b),
    .y  (cmp_y)
  );

  writeback_sel #(
    .data_width (data_width)
  ) u_wb (
    .clk     (clk),
    .arst_n  (arst_n),
    .dec     (ex_q),
    .alu_y   (alu_y),
    .cmp_y   (cmp_y),
    .wb      (wb),
    .illegal (illegal)
  );

  assign result = wb;    // valid pulses two edges after the strobe

endmodule

`default_nettype wire

//--- test/exec_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module exec_core_tb;
  import rf_pkg::*;

  // one expected outcome per accepted strobe
  typedef struct packed {
    logic        valid;    // result.valid expected
    logic        illegal;  // illegal pulse expected
    logic [4:0]  rd;
    logic [31:0] data;
    logic [31:0] due;      // cycle count at which the outcome is visible
  } exp_t;

  logic   clk;
  logic   arst_n;
  logic   instr_valid;
  instr_u instr;
  wb_t    result;
  logic   illegal;

  logic [31:0] model [32];  // reference register file with r0 held at 0
  logic [31:0] lfsr;        // galois lfsr state
  exp_t        exp_q [$];   // outcomes in flight
  string       name_q [$];  // test name for each queued outcome
  int          cyc;         // rising edges seen
  int          value_errs;
  int          other_errs;

  exec_core #(
    .data_width (xlen)
  ) dut (
    .clk         (clk),
    .arst_n      (arst_n),
    .instr_valid (instr_valid),
    .instr       (instr),
    .result      (result),
    .illegal     (illegal)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;  // 4 ns period
  end

  always @(posedge clk) cyc++;

  //////////////////////////////////////////////////////////////////////
  // stimulus helpers
  //////////////////////////////////////////////////////////////////////
  // one lfsr step per bit with bits shifted in msb first
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      v    = {v[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    end
    return v;
  endfunction

  function automatic logic [31:0] rr_word(input logic [4:0] opc, input logic [4:0] rd,
                                          input logic [4:0] rs1, input logic [4:0] rs2);
    return {opc, rd, rs1, rs2, 12'h000};
  endfunction

  function automatic logic [31:0] ri_word(input logic [4:0] opc, input logic [4:0] rd,
                                          input logic [4:0] rs1, input logic [16:0] imm);
    return {opc, rd, rs1, imm};
  endfunction

  // expected outcome from the instruction rules and the model registers
  function automatic exp_t predict(input logic [31:0] word);
    logic [4:0]  opc;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] simm;
    exp_t        e;
    opc  = word[31:27];
    a    = model[word[21:17]];
    b    = model[word[16:12]];
    simm = {{15{word[16]}}, word[16:0]};   // signed 17 bit immediate
    e    = '{valid: 1'b1, illegal: 1'b0, rd: word[26:22], data: '0, due: '0};
    case (opc)
      op_add:  e.data = a + b;              // wraps mod 2^32
      op_sub:  e.data = a - b;
      op_and:  e.data = a & b;
      op_or:   e.data = a | b;
      op_xor:  e.data = a ^ b;
      op_sll:  e.data = a << b[4:0];        // low 5 bits only
      op_srl:  e.data = a >> b[4:0];
      op_eq:   e.data = {31'd0, a == b};
      op_slt:  e.data = {31'd0, ((a[31] != b[31]) ? a[31] : (a < b))};  // sign bit decides first
      op_sltu: e.data = {31'd0, a < b};
      op_addi: e.data = a + simm;
      op_andi: e.data = a & simm;
      op_ori:  e.data = a | simm;
      op_xori: e.data = a ^ simm;
      default: begin
        e.valid   = 1'b0;                   // no result and no write
        e.illegal = 1'b1;
      end
    endcase
    return e;
  endfunction

  task automatic issue(input string name, input logic [31:0] word);
    exp_t e;
    @(posedge clk);
    #0.5;
    instr_valid = 1'b1;
    instr       = word;
    e           = predict(word);
    e.due       = cyc + 2;                  // two edges of latency
    if (e.valid && e.rd != 5'd0)
      model[e.rd] = e.data;                 // update now so dependents see it
    exp_q.push_back(e);
    name_q.push_back(name);
  endtask

  task automatic idle_cycles(input int n);
    for (int k = 0; k < n; k++) begin
      @(posedge clk);
      #0.5;
      instr_valid = 1'b0;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // checking mid cycle where the outputs are stable
  //////////////////////////////////////////////////////////////////////
  task automatic value_error(input string name, input string field,
                             input logic [31:0] exp_v, input logic [31:0] act_v);
    $display("error %s %s expected %h actual %h", name, field, exp_v, act_v);
    value_errs++;
  endtask

  task automatic check_outcome(input string name, input exp_t e);
    assert (result.valid === e.valid)
      else value_error(name, "valid", e.valid, result.valid);
    assert (illegal === e.illegal)
      else value_error(name, "illegal", e.illegal, illegal);
    if (e.valid) begin
      assert (result.rd === e.rd)
        else value_error(name, "rd", e.rd, result.rd);
      assert (result.data === e.data)
        else value_error(name, "data", e.data, result.data);
    end
  endtask

  always @(negedge clk) begin : check_outputs
    exp_t  e;
    string nm;
    if (arst_n) begin
      if (exp_q.size() != 0 && exp_q[0].due == cyc) begin
        e  = exp_q.pop_front();
        nm = name_q.pop_front();
        check_outcome(nm, e);
      end else begin
        assert (result.valid === 1'b0 && illegal === 1'b0) else begin
          $display("output pulse at cycle %0d with no instruction due", cyc);
          other_errs++;
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////////////////////////
  initial begin : run
    logic [31:0] word;
    arst_n      = 1'b0;
    instr_valid = 1'b0;
    instr       = '0;
    lfsr        = 32'd9;
    cyc         = 0;
    value_errs  = 0;
    other_errs  = 0;
    for (int k = 0; k < 32; k++) model[k] = '0;
    repeat (5) @(posedge clk);
    #0.5;
    arst_n = 1'b1;
    idle_cycles(4);                          // quiet outputs after reset

    issue("addi_pos",   ri_word(op_addi, 5'd1, 5'd0, 17'h0ffff));  // r1 = 65535
    issue("addi_neg",   ri_word(op_addi, 5'd2, 5'd0, 17'h1ffff));  // r2 = -1
    issue("add_wrap",   rr_word(op_add,  5'd3, 5'd2, 5'd2));       // uses r2 back to back
    issue("sub_wrap",   rr_word(op_sub,  5'd4, 5'd0, 5'd1));
    issue("addi_shamt", ri_word(op_addi, 5'd5, 5'd0, 17'd33));     // 33 -> shift by 1
    issue("sll_low5",   rr_word(op_sll,  5'd6, 5'd1, 5'd5));
    issue("srl_low5",   rr_word(op_srl,  5'd7, 5'd2, 5'd5));
    issue("andi_neg",   ri_word(op_andi, 5'd8, 5'd1, 17'h10f0f));
    issue("ori_neg",    ri_word(op_ori,  5'd8, 5'd8, 17'h18000));
    issue("xori_pos",   ri_word(op_xori, 5'd8, 5'd8, 17'h00ff0));
    issue("and_rr",     rr_word(op_and,  5'd9, 5'd8, 5'd1));
    issue("or_rr",      rr_word(op_or,   5'd9, 5'd9, 5'd6));
    issue("xor_rr",     rr_word(op_xor,  5'd9, 5'd9, 5'd2));
    // signed and unsigned order disagree for -1 against 65535
    issue("slt_sign",   rr_word(op_slt,  5'd10, 5'd2, 5'd1));
    issue("sltu_sign",  rr_word(op_sltu, 5'd11, 5'd2, 5'd1));
    issue("slt_rev",    rr_word(op_slt,  5'd10, 5'd1, 5'd2));
    issue("sltu_rev",   rr_word(op_sltu, 5'd11, 5'd1, 5'd2));
    issue("eq_same",    rr_word(op_eq,   5'd12, 5'd1, 5'd1));
    issue("eq_diff",    rr_word(op_eq,   5'd12, 5'd1, 5'd2));
    issue("b2b_prod",   ri_word(op_addi, 5'd13, 5'd0, 17'd5));
    issue("b2b_cons",   rr_word(op_add,  5'd14, 5'd13, 5'd13));
    issue("gap_prod",   ri_word(op_addi, 5'd15, 5'd0, 17'd7));
    idle_cycles(1);
    issue("gap_cons",   rr_word(op_add,  5'd16, 5'd15, 5'd15));
    issue("wr_r0",      ri_word(op_addi, 5'd0, 5'd0, 17'd123));   // result shows but nothing is written
    issue("rd_r0",      rr_word(op_add,  5'd17, 5'd0, 5'd0));
    issue("rd_r0_gap",  rr_word(op_or,   5'd17, 5'd0, 5'd0));     // read while r0 write commits
    issue("illegal_7",  rr_word(5'd7,    5'd1, 5'd2, 5'd2));      // r1 must survive
    issue("illegal_31", ri_word(5'd31,   5'd1, 5'd0, 17'd9));
    issue("rd_after_il", rr_word(op_add, 5'd18, 5'd1, 5'd0));
    idle_cycles(2);

    // random mix, illegal codes included
    for (int n = 0; n < 80; n++) begin
      word = rand_bits(32);                  // opcode, rd, rs1 and rs2 or immediate
      issue("random", word);
      if (rand_bits(2) == 0)
        idle_cycles(1);
    end
    idle_cycles(1);

    for (int t = 0; t < 10 && exp_q.size() != 0; t++) begin
      @(posedge clk);
    end
    if (exp_q.size() != 0) begin
      $display("timeout: %0d results never appeared", exp_q.size());
      other_errs++;
    end
    idle_cycles(2);

    $display("errors: value %0d other %0d", value_errs, other_errs);
    if (value_errs == 0 && other_errs == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sim.f
design/rf_pkg.sv
design/instr_decode.sv
design/reg_file.sv
design/alu_unit.sv
design/compare_unit.sv
design/writeback_sel.sv
design/exec_core.sv
test/exec_core_tb.sv
